// File: run_sim.sh
#!/usr/bin/env bash
# Build the controller testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -j 0 --top-module tb_cpu_ctrl -f tb.f -o tb_cpu_ctrl \
    && ./obj_dir/tb_cpu_ctrl > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1
exit 0

// File: src/console_decoder.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module console_decoder
    import cpu_ctrl_pkg::*;
(
    input  sw_mode_t             sw,
    input  logic [`CTRL_BEATS:1] w,
    input  logic                 st0,
    output ctrl_word_t           console_word,
    output logic                 st0_set,
    output logic                 st0_clear
);

    // Register select patterns as {Rd, Rs} per beat
    localparam logic [`CTRL_SEL_W-1:0] SEL_RD_W1    = 4'b0001;
    localparam logic [`CTRL_SEL_W-1:0] SEL_RD_W2    = 4'b1011;
    localparam logic [`CTRL_SEL_W-1:0] SEL_WR_LO_W1 = 4'b0011;
    localparam logic [`CTRL_SEL_W-1:0] SEL_WR_LO_W2 = 4'b0100;
    localparam logic [`CTRL_SEL_W-1:0] SEL_WR_HI_W1 = 4'b1001;
    localparam logic [`CTRL_SEL_W-1:0] SEL_WR_HI_W2 = 4'b1110;

    logic w12;

    assign w12 = w[1] | w[2];

    always_comb begin
        console_word = '0;
        st0_set      = 1'b0;
        st0_clear    = 1'b0;

        case (sw)
            mode_write_mem: begin
                console_word.sbus   = w[1];
                console_word.stop   = w[1];
                console_word.short  = w[1];
                console_word.selctl = w[1];
                console_word.lar    = w[1] & ~st0;   // First step loads address
                console_word.memw   = w[1] & st0;
                console_word.arinc  = w[1] & st0;
                st0_set             = w[1];
            end
            mode_read_mem: begin
                console_word.stop   = w[1];
                console_word.short  = w[1];
                console_word.selctl = w[1];
                console_word.sbus   = w[1] & ~st0;
                console_word.lar    = w[1] & ~st0;
                console_word.mbus   = w[1] & st0;    // Then stream out
                console_word.arinc  = w[1] & st0;
                st0_set             = w[1] & ~st0;
            end
            mode_read_reg: begin
                console_word.selctl = w12;
                console_word.stop   = w12;
                if (w[1]) begin
                    console_word.sel = SEL_RD_W1;
                end else if (w[2]) begin
                    console_word.sel = SEL_RD_W2;
                end
            end
            mode_write_reg: begin
                console_word.sbus   = w12;
                console_word.selctl = w12;
                console_word.drw    = w12;
                console_word.stop   = w12;
                if (w[1]) begin
                    console_word.sel = st0 ? SEL_WR_HI_W1 : SEL_WR_LO_W1;
                end else if (w[2]) begin
                    console_word.sel = st0 ? SEL_WR_HI_W2 : SEL_WR_LO_W2;
                end
                st0_set   = w[2] & ~st0;
                st0_clear = w[2] & st0;              // Back to R0/R1 pair
            end
            default: begin
                console_word = '0;                   // Exec mode
            end
        endcase
    end

    // Address register is either loaded or stepped, never both
    always_comb begin
        no_lar_arinc: assert final (!(console_word.lar && console_word.arinc))
            else $error("lar and arinc high together, sw=%0d st0=%b", sw, st0);
    end

endmodule

// File: src/cpu_ctrl_pkg.sv
`include "cpu_ctrl_settings.svh"

package cpu_ctrl_pkg;

    // Console switch positions
    typedef enum logic [`CTRL_SW_W-1:0] {
        mode_exec      = 3'b000,
        mode_write_mem = 3'b001,
        mode_read_mem  = 3'b010,
        mode_read_reg  = 3'b011,
        mode_write_reg = 3'b100
    } sw_mode_t;

    // Upper nibble of the instruction register
    typedef enum logic [`CTRL_IR_W-1:0] {
        op_add = 4'd1,
        op_sub = 4'd2,
        op_and = 4'd3,
        op_inc = 4'd4,
        op_ld  = 4'd5,
        op_st  = 4'd6,
        op_jc  = 4'd7,
        op_jz  = 4'd8,
        op_jmp = 4'd9,
        op_out = 4'd10,
        op_or  = 4'd12,
        op_xor = 4'd13,
        op_stp = 4'd14
    } opcode_t;

    // One microinstruction in box connector order
    typedef struct packed {
        logic                   ldc;
        logic                   ldz;
        logic                   cin;
        logic [`CTRL_S_W-1:0]   s;
        logic [`CTRL_SEL_W-1:0] sel;
        logic                   m;
        logic                   abus;
        logic                   drw;
        logic                   pcinc;
        logic                   lpc;
        logic                   lar;
        logic                   pcadd;
        logic                   arinc;
        logic                   selctl;
        logic                   memw;
        logic                   stop;
        logic                   lir;
        logic                   sbus;
        logic                   mbus;
        logic                   short;
        logic                   long;
    } ctrl_word_t;

endpackage

// File: src/cpu_ctrl_settings.svh
`ifndef CPU_CTRL_SETTINGS_SVH
`define CPU_CTRL_SETTINGS_SVH

// Field widths of the lab box interface
`define CTRL_SW_W   3
`define CTRL_IR_W   4
`define CTRL_BEATS  3
`define CTRL_S_W    4
`define CTRL_SEL_W  4

// ALU function codes for the 74181 style ALU
`define ALU_S_ADD     4'b1001
`define ALU_S_SUB     4'b0110
`define ALU_S_AND     4'b1011
`define ALU_S_OR      4'b1110
`define ALU_S_XOR     4'b0110   // Logic mode only
`define ALU_S_PASS_A  4'b1111
`define ALU_S_PASS_B  4'b1010
`define ALU_S_INC     4'b0000
`define ALU_S_DEFAULT 4'b0000

`endif

// File: src/cpu_ctrl_top.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module cpu_ctrl_top
    import cpu_ctrl_pkg::*;
(
    input  logic                   t3,
    input  logic                   arst_n,
    input  logic [`CTRL_SW_W-1:0]  sw,
    input  logic [`CTRL_IR_W-1:0]  ir,
    input  logic [`CTRL_BEATS:1]   w,
    input  logic                   c,
    input  logic                   z,
    output logic                   ldc,
    output logic                   ldz,
    output logic                   cin,
    output logic [`CTRL_S_W-1:0]   s,
    output logic [`CTRL_SEL_W-1:0] sel,
    output logic                   m,
    output logic                   abus,
    output logic                   drw,
    output logic                   pcinc,
    output logic                   lpc,
    output logic                   lar,
    output logic                   pcadd,
    output logic                   arinc,
    output logic                   selctl,
    output logic                   memw,
    output logic                   stop,
    output logic                   lir,
    output logic                   sbus,
    output logic                   mbus,
    output logic                   short,
    output logic                   long
);

    ctrl_word_t exec_word;
    ctrl_word_t console_word;
    ctrl_word_t ctrl;
    logic       st0;
    logic       st0_set;
    logic       st0_clear;

    instr_decoder i_instr_decoder (
        .ir        (opcode_t'(ir)),
        .w         (w),
        .c         (c),
        .z         (z),
        .exec_word (exec_word)
    );

    console_decoder i_console_decoder (
        .sw           (sw_mode_t'(sw)),
        .w            (w),
        .st0          (st0),
        .console_word (console_word),
        .st0_set      (st0_set),
        .st0_clear    (st0_clear)
    );

    mode_sequencer i_mode_sequencer (
        .t3           (t3),
        .arst_n       (arst_n),
        .sw           (sw_mode_t'(sw)),
        .exec_word    (exec_word),
        .console_word (console_word),
        .st0_set      (st0_set),
        .st0_clear    (st0_clear),
        .st0          (st0),
        .ctrl         (ctrl)
    );

    // Same order as ctrl_word_t
    assign {ldc, ldz, cin, s, sel, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
            selctl, memw, stop, lir, sbus, mbus, short, long} = ctrl;

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module instr_decoder
    import cpu_ctrl_pkg::*;
(
    input  opcode_t             ir,
    input  logic [`CTRL_BEATS:1] w,
    input  logic                c,
    input  logic                z,
    output ctrl_word_t          exec_word
);

    always_comb begin
        exec_word       = '0;
        exec_word.s     = `ALU_S_DEFAULT;

        // Fetch beat is the same for every opcode
        exec_word.lir   = w[1];
        exec_word.pcinc = w[1];

        if (w[2]) begin
            case (ir)
                op_add: begin
                    exec_word.s    = `ALU_S_ADD;
                    exec_word.cin  = 1'b1;
                    exec_word.abus = 1'b1;
                    exec_word.drw  = 1'b1;
                    exec_word.ldz  = 1'b1;
                    exec_word.ldc  = 1'b1;
                end
                op_sub: begin
                    exec_word.s    = `ALU_S_SUB;
                    exec_word.abus = 1'b1;
                    exec_word.drw  = 1'b1;
                    exec_word.ldz  = 1'b1;
                    exec_word.ldc  = 1'b1;
                end
                op_inc: begin
                    exec_word.s    = `ALU_S_INC;
                    exec_word.abus = 1'b1;
                    exec_word.drw  = 1'b1;
                    exec_word.ldz  = 1'b1;
                    exec_word.ldc  = 1'b1;
                end
                op_and, op_or, op_xor: begin
                    // Logic ops leave carry alone
                    exec_word.m    = 1'b1;
                    exec_word.abus = 1'b1;
                    exec_word.drw  = 1'b1;
                    exec_word.ldz  = 1'b1;
                    case (ir)
                        op_and:  exec_word.s = `ALU_S_AND;
                        op_or:   exec_word.s = `ALU_S_OR;
                        default: exec_word.s = `ALU_S_XOR;
                    endcase
                end
                op_ld: begin
                    exec_word.m    = 1'b1;
                    exec_word.s    = `ALU_S_PASS_B;  // Address from Rs
                    exec_word.abus = 1'b1;
                    exec_word.lar  = 1'b1;
                    exec_word.long = 1'b1;
                end
                op_st: begin
                    exec_word.m    = 1'b1;
                    exec_word.s    = `ALU_S_PASS_A;
                    exec_word.abus = 1'b1;
                    exec_word.lar  = 1'b1;
                    exec_word.long = 1'b1;
                end
                op_jc:  exec_word.pcadd = c;
                op_jz:  exec_word.pcadd = z;
                op_jmp: begin
                    exec_word.m    = 1'b1;
                    exec_word.s    = `ALU_S_PASS_A;
                    exec_word.abus = 1'b1;
                    exec_word.lpc  = 1'b1;
                end
                op_out: begin
                    exec_word.m    = 1'b1;
                    exec_word.s    = `ALU_S_PASS_B;
                    exec_word.abus = 1'b1;
                end
                op_stp: exec_word.stop = 1'b1;
                default: begin
                    exec_word.s = `ALU_S_DEFAULT;
                end
            endcase
        end

        // Memory beat of LD and ST
        if (w[3]) begin
            case (ir)
                op_ld: begin
                    exec_word.drw  = 1'b1;
                    exec_word.mbus = 1'b1;
                end
                op_st: begin
                    exec_word.m    = 1'b1;
                    exec_word.s    = `ALU_S_PASS_B;  // Data from Rd
                    exec_word.abus = 1'b1;
                    exec_word.memw = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Register file and memory never share one beat
    always_comb begin
        no_memw_drw: assert final (!(exec_word.memw && exec_word.drw))
            else $error("memw and drw high together, ir=%0d w=%b", ir, w);
    end

endmodule

// File: src/mode_sequencer.sv
`timescale 1ns/1ps

module mode_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic       t3,
    input  logic       arst_n,
    input  sw_mode_t   sw,
    input  ctrl_word_t exec_word,
    input  ctrl_word_t console_word,
    input  logic       st0_set,
    input  logic       st0_clear,
    output logic       st0,
    output ctrl_word_t ctrl
);

    // Phase flag for two-step console operations
    always_ff @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            st0 <= 1'b0;
        end else if (st0_set) begin
            st0 <= 1'b1;            // Set wins over clear
        end else if (st0_clear) begin
            st0 <= 1'b0;
        end
    end

    // Word source follows the console switches
    always_comb begin
        case (sw)
            mode_exec: begin
                ctrl = exec_word;
            end
            mode_write_mem,
            mode_read_mem,
            mode_read_reg,
            mode_write_reg: begin
                ctrl = console_word;
            end
            default: begin
                ctrl = '0;          // Codes 101 to 111 unused
            end
        endcase
    end

    // Console decoder must never request both edges of st0 at once
    st0_req_excl: assert property (
        @(posedge t3) disable iff (!arst_n)
        !(st0_set && st0_clear)
    ) else $error("st0_set and st0_clear high together");

    // Outside the console modes nothing may touch the memory address path
    exec_no_console_ar: assert property (
        @(posedge t3) disable iff (!arst_n)
        (sw == mode_exec) |-> !(ctrl.arinc || ctrl.selctl)
    ) else $error("console address control seen in exec mode");

endmodule

// File: tb.f
+incdir+src
src/cpu_ctrl_pkg.sv
src/mode_sequencer.sv
src/instr_decoder.sv
src/console_decoder.sv
src/cpu_ctrl_top.sv
test/ctrl_checker.sv
test/tb_cpu_ctrl.sv

// File: test/cpu_ctrl_tests.txt
# Rows: "test NAME" opens a case; "step sw ir w c z word" gives one beat (sw, ir, word in hex, w as w3 w2 w1)
# Word nibbles: {ldc ldz cin} s sel {m abus drw pcinc} {lpc lar pcadd arinc} {selctl memw stop lir} {sbus mbus short long}
test reset_idle
step 0 1 000 0 0 0000000
step 1 0 000 0 0 0000000
step 2 0 000 0 0 0000000
step 3 0 000 0 0 0000000
step 4 0 000 0 0 0000000
step 5 0 001 0 0 0000000
test alu_ops
step 0 1 001 0 0 0001010
step 0 1 010 0 0 7906000
step 0 2 010 0 0 6606000
step 0 3 010 0 0 2b0e000
step 0 4 010 0 0 6006000
step 0 c 010 0 0 2e0e000
step 0 d 010 0 0 260e000
test mem_jump_ops
step 0 5 010 0 0 0a0c401
step 0 5 100 0 0 0002004
step 0 6 010 0 0 0f0c401
step 0 6 100 0 0 0a0c040
step 0 9 010 0 0 0f0c800
step 0 a 010 0 0 0a0c000
step 0 e 010 0 0 0000020
test cond_jumps
step 0 7 001 1 0 0001010
step 0 7 010 1 0 0000200
step 0 7 010 0 1 0000000
step 0 8 010 0 1 0000200
step 0 8 010 1 0 0000000
test read_reg
step 3 0 001 0 0 00100a0
step 3 0 010 0 0 00b00a0
test write_reg
step 4 0 001 0 0 00320a8
step 4 0 010 0 0 00420a8
step 4 0 001 0 0 00920a8
step 4 0 010 0 0 00e20a8
step 4 0 001 0 0 00320a8
step 4 0 010 0 0 00420a8
step 4 0 001 0 0 00920a8
step 4 0 010 0 0 00e20a8
test write_mem
step 1 0 001 0 0 00004aa
step 1 0 001 0 0 00001ea
step 1 0 001 0 0 00001ea
test phase_clear
step 4 0 010 0 0 00e20a8
test read_mem
step 2 0 001 0 0 00004aa
step 2 0 001 0 0 00001a6
step 2 0 001 0 0 00001a6

// File: test/ctrl_checker.sv
`timescale 1ns/1ps

module ctrl_checker
    import cpu_ctrl_pkg::*;
(
    input  logic                          t3,
    input  logic                          arst_n,
    input  logic                          step_valid,
    input  logic [$bits(ctrl_word_t)-1:0] exp_word,
    input  logic                          ldc,
    input  logic                          ldz,
    input  logic                          cin,
    input  logic [3:0]                    s,
    input  logic [3:0]                    sel,
    input  logic                          m,
    input  logic                          abus,
    input  logic                          drw,
    input  logic                          pcinc,
    input  logic                          lpc,
    input  logic                          lar,
    input  logic                          pcadd,
    input  logic                          arinc,
    input  logic                          selctl,
    input  logic                          memw,
    input  logic                          stop,
    input  logic                          lir,
    input  logic                          sbus,
    input  logic                          mbus,
    input  logic                          short,
    input  logic                          long,
    output int                            fail_tests,
    output int                            mismatch_count
);

    logic [$bits(ctrl_word_t)-1:0] got_word;
    string                         cur_name;
    int                            cur_steps;
    int                            cur_errors;
    int                            pass_tests;

    // Box connector order with MSB first
    assign got_word = {ldc, ldz, cin, s, sel, m, abus, drw, pcinc, lpc, lar, pcadd,
                       arinc, selctl, memw, stop, lir, sbus, mbus, short, long};

    initial begin
        cur_name       = "";
        cur_steps      = 0;
        cur_errors     = 0;
        pass_tests     = 0;
        fail_tests     = 0;
        mismatch_count = 0;
    end

    // Inputs settle at the falling edge, so the rising edge sees stable values
    always @(posedge t3) begin
        if (arst_n && step_valid) begin
            cur_steps = cur_steps + 1;
            if (got_word !== exp_word) begin
                cur_errors     = cur_errors + 1;
                mismatch_count = mismatch_count + 1;
                $display("[ERROR] %0t ns: %s step %0d expected %07h got %07h (diff %07h)",
                         $time, cur_name, cur_steps, exp_word, got_word,
                         exp_word ^ got_word);
            end
        end
    end

    task automatic start_test(input string name);
        cur_name   = name;
        cur_steps  = 0;
        cur_errors = 0;
    endtask

    task automatic end_test();
        if (cur_steps == 0) begin
            fail_tests = fail_tests + 1;
            $display("FAIL %s: no stimulus rows were applied", cur_name);
        end else if (cur_errors == 0) begin
            pass_tests = pass_tests + 1;
            $display("PASS %s (%0d steps)", cur_name, cur_steps);
        end else begin
            fail_tests = fail_tests + 1;
            $display("FAIL %s (%0d of %0d steps wrong)", cur_name, cur_errors, cur_steps);
        end
    endtask

    task automatic print_totals();
        $display("Totals: passed %0d, failed %0d, mismatched steps %0d",
                 pass_tests, fail_tests, mismatch_count);
    endtask

endmodule

// File: test/tb_cpu_ctrl.sv
`timescale 1ns/1ps
`include "cpu_ctrl_settings.svh"

module tb_cpu_ctrl
    import cpu_ctrl_pkg::*;
();

    localparam int    RESET_CYCLES = 16;
    localparam int    SLACK_CYCLES = 20;
    localparam int    WORD_W       = $bits(ctrl_word_t);
    localparam string TESTS_FILE   = "test/cpu_ctrl_tests.txt";

    logic                   t3;
    logic                   arst_n;
    logic [`CTRL_SW_W-1:0]  sw;
    logic [`CTRL_IR_W-1:0]  ir;
    logic [`CTRL_BEATS:1]   w;
    logic                   c;
    logic                   z;
    logic                   ldc, ldz, cin;
    logic [`CTRL_S_W-1:0]   s;
    logic [`CTRL_SEL_W-1:0] sel;
    logic                   m, abus, drw, pcinc, lpc, lar, pcadd, arinc;
    logic                   selctl, memw, stop, lir, sbus, mbus, short, long;
    logic [WORD_W-1:0]      exp_word;
    logic                   step_valid;
    int                     fail_tests;
    int                     mismatch_count;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;

    initial t3 = 1'b0;
    always #5 t3 = ~t3;

    cpu_ctrl_top i_cpu_ctrl_top (.*);

    ctrl_checker i_ctrl_checker (.*);

    // Run limit armed once the stimulus rows are counted
    always @(posedge t3) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    function automatic int count_steps();
        int               fd;
        int               n;
        int               got;
        string            tok;
        logic [8*200-1:0] skip_buf;
        n = 0;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            return -1;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                got = $fgets(skip_buf, fd);
            end else if (tok == "step") begin
                n = n + 1;
            end
        end
        $fclose(fd);
        return n;
    endfunction

    task automatic apply_step(input logic [`CTRL_SW_W-1:0] sw_v,
                              input logic [`CTRL_IR_W-1:0] ir_v,
                              input logic [`CTRL_BEATS:1]  w_v,
                              input logic                  c_v,
                              input logic                  z_v,
                              input logic [WORD_W-1:0]     exp_v);
        @(negedge t3);
        sw         = sw_v;
        ir         = ir_v;
        w          = w_v;
        c          = c_v;
        z          = z_v;
        exp_word   = exp_v;
        step_valid = 1'b1;
    endtask

    task automatic close_test();
        @(negedge t3);
        step_valid = 1'b0;
        w          = '0;    // Idle beat keeps st0
        i_ctrl_checker.end_test();
    endtask

    initial begin
        int                    fd;
        int                    n_steps;
        int                    n_tests;
        int                    bad_entries;
        int                    got;
        bit                    test_open;
        string                 kind;
        string                 name;
        logic [8*200-1:0]      skip_buf;
        logic [`CTRL_SW_W-1:0] sw_v;
        logic [`CTRL_IR_W-1:0] ir_v;
        logic [`CTRL_BEATS:1]  w_v;
        logic                  c_v;
        logic                  z_v;
        logic [WORD_W-1:0]     exp_v;

        arst_n      = 1'b0;
        sw          = '0;
        ir          = '0;
        w           = '0;
        c           = 1'b0;
        z           = 1'b0;
        exp_word    = '0;
        step_valid  = 1'b0;
        n_tests     = 0;
        bad_entries = 0;
        test_open   = 1'b0;
        name        = "";

        n_steps = count_steps();
        if (n_steps < 0) begin
            $display("Stimulus file %s could not be opened", TESTS_FILE);
            $display("tests failed");
            $finish;
        end else begin
            cycle_limit = RESET_CYCLES + n_steps + SLACK_CYCLES;
            repeat (RESET_CYCLES) @(posedge t3);
            @(negedge t3);
            arst_n = 1'b1;

            fd = $fopen(TESTS_FILE, "r");
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind.substr(0, 0) == "#") begin
                    got = $fgets(skip_buf, fd);
                end else if (kind == "test") begin
                    got = $fscanf(fd, "%s", name);
                    if (test_open) begin
                        close_test();
                    end
                    i_ctrl_checker.start_test(name);
                    test_open = 1'b1;
                    n_tests   = n_tests + 1;
                end else if (kind == "step" && test_open) begin
                    got = $fscanf(fd, "%h %h %b %b %b %h", sw_v, ir_v, w_v, c_v, z_v, exp_v);
                    if (got == 6) begin
                        apply_step(sw_v, ir_v, w_v, c_v, z_v, exp_v);
                    end else begin
                        bad_entries = bad_entries + 1;
                        $display("Malformed stimulus row in %s", name);
                    end
                end else begin
                    bad_entries = bad_entries + 1;
                    $display("Unexpected entry '%s' in stimulus file", kind);
                end
            end
            $fclose(fd);
            if (test_open) begin
                close_test();
            end

            i_ctrl_checker.print_totals();
            if (n_tests > 0 && fail_tests == 0 && mismatch_count == 0 && bad_entries == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule
